// File: rtl/grp16_pkg.sv
// shared GRP16 types; opcode values follow the GRP16 encoding, only a subset is decoded
package grp16_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////
   typedef logic [15:0] word_t;     // data, instruction or address word
   typedef logic [3:0]  reg_sel_t;  // register code as found in the instruction

   // high byte of an instruction
   typedef enum logic [7:0] {
      op_li  = 8'hA1,   // two words, imm in second
      op_add = 8'h43,
      op_sub = 8'h44,
      op_and = 8'h47,
      op_or  = 8'h48,
      op_cmp = 8'h49,   // unsigned less-than
      op_nop = 8'h0F
   } opcode_t;

   typedef enum logic [3:0] {
      alu_and = 4'h0,
      alu_or  = 4'h1,
      alu_add = 4'h5,
      alu_sub = 4'h6,
      alu_slt = 4'h9
   } alu_op_t;

   typedef enum logic {
      first_word  = 1'b0,
      second_word = 1'b1   // holding the first half of a long instr
   } asm_state_t;

   ////////////////////////////////////////////////////////////
   // stage records
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      word_t instr;
      word_t imm;     // zero for single-word instrs
   } instr_pkt_t;

   typedef struct packed {
      word_t    a;          // operand a, already read
      word_t    b;          // operand b, already read
      word_t    imm;
      reg_sel_t dest;
      logic     reg_write;
      alu_op_t  alu_op;
      logic     use_imm;    // b comes from imm
   } decode_pkt_t;

   typedef struct packed {
      logic     en;
      reg_sel_t dest;
      word_t    data;
   } wb_t;

   localparam word_t    nop_instr    = 16'h0F00;
   localparam reg_sel_t sel_zero     = 4'd0;  // reads constant 0
   localparam reg_sel_t sel_one      = 4'd1;  // reads constant 1
   localparam reg_sel_t sel_first_gp = 4'd2;  // r0, r1..r3 follow

endpackage

// File: rtl/fetch_unit.sv
// mem_depth must be a power of two; only the low log2(mem_depth) PC bits address the memory
`timescale 1ns/10ps

module fetch_unit import grp16_pkg::*; #(
   parameter int mem_depth = 512
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  redirect,      // one-cycle strobe
   input  word_t redirect_pc,
   input  logic  load_en,       // program load, independent of pc
   input  word_t load_addr,
   input  word_t load_data,
   output word_t pc,
   output word_t fetch_word
);

   localparam int addr_w = $clog2(mem_depth);

   word_t pc_q;
   word_t pc_next;
   word_t mem [mem_depth];

   ////////////////////////////////////////////////////////////
   // program counter
   ////////////////////////////////////////////////////////////
   always_comb begin
      if (redirect) begin
         pc_next = redirect_pc;
      end else begin
         pc_next = pc_q + 16'd1;   // plain increment
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q <= '0;
      end else begin
         pc_q <= pc_next;
      end
   end

   assign pc = pc_q;

   ////////////////////////////////////////////////////////////
   // instruction memory
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr[addr_w-1:0]] <= load_data;
      end
      fetch_word <= mem[pc_q[addr_w-1:0]];   // word at pc, one cycle later
   end

   // loads past the array would alias onto low addresses
   a_load_in_range: assert property (@(posedge clk) load_en |-> (load_addr < mem_depth))
      else $error("load_addr %h beyond memory depth", load_addr);

endmodule

// File: rtl/word_assembler.sv
// long instrs are paired blindly; a redirect between the two words of a long instr is not handled
`timescale 1ns/10ps

module word_assembler import grp16_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  word_t      fetch_word,
   output instr_pkt_t instr
);

   asm_state_t state_q;
   word_t      held_q;     // first word of a long instr
   instr_pkt_t instr_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= first_word;
         instr_q <= '{instr: nop_instr, imm: '0};
      end else begin
         case (state_q)
            first_word: begin
               if (fetch_word[15]) begin            // two-word form
                  held_q  <= fetch_word;
                  instr_q <= '{instr: nop_instr, imm: '0};   // bubble
                  state_q <= second_word;
               end else begin
                  instr_q <= '{instr: fetch_word, imm: '0};
               end
            end
            second_word: begin
               instr_q <= '{instr: held_q, imm: fetch_word};  // word 2 is the imm
               state_q <= first_word;
            end
            default: begin
               state_q <= first_word;
            end
         endcase
      end
   end

   assign instr = instr_q;

   // fetched words must be known once the core runs
   a_fetch_known: assert property (
      @(posedge clk) disable iff (rst)
      !$isunknown(fetch_word)
   ) else $error("unknown fetch word %h", fetch_word);

endmodule

// File: rtl/decoder.sv
// only LI and the five ALU ops write; any other opcode, valid or not, decodes as a no-op
`timescale 1ns/10ps

module decoder import grp16_pkg::*; (
   input  instr_pkt_t  instr,
   output reg_sel_t    rd_sel_a,
   output reg_sel_t    rd_sel_b,
   input  word_t       rd_a,
   input  word_t       rd_b,
   output decode_pkt_t dec
);

   opcode_t  op;
   reg_sel_t fld_hi;   // bits 7:4, dest and operand a
   reg_sel_t fld_lo;   // bits 3:0, operand b

   assign op     = opcode_t'(instr.instr[15:8]);
   assign fld_hi = instr.instr[7:4];
   assign fld_lo = instr.instr[3:0];

   always_comb begin
      // defaults give a harmless bubble
      rd_sel_a      = sel_zero;
      rd_sel_b      = sel_zero;
      dec.dest      = fld_hi;
      dec.reg_write = 1'b0;
      dec.alu_op    = alu_add;
      dec.use_imm   = 1'b0;

      case (op)
         op_li: begin
            dec.reg_write = 1'b1;   // 0 + imm
            dec.use_imm   = 1'b1;
         end
         op_add, op_sub, op_and, op_or, op_cmp: begin
            rd_sel_a      = fld_hi;
            rd_sel_b      = fld_lo;
            dec.reg_write = 1'b1;
            case (op)
               op_sub:  dec.alu_op = alu_sub;
               op_and:  dec.alu_op = alu_and;
               op_or:   dec.alu_op = alu_or;
               op_cmp:  dec.alu_op = alu_slt;
               default: dec.alu_op = alu_add;
            endcase
         end
         default: begin
            dec.reg_write = 1'b0;   // nop, dropped ops
         end
      endcase

      dec.a   = rd_a;
      dec.b   = rd_b;
      dec.imm = instr.imm;
   end

endmodule

// File: rtl/reg_file.sv
// codes 0 and 1 are read-only constants; codes above 5 read as zero and are never written
`timescale 1ns/10ps

module reg_file import grp16_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  reg_sel_t rd_sel_a,
   input  reg_sel_t rd_sel_b,
   output word_t    rd_a,
   output word_t    rd_b,
   input  wb_t      wb
);

   word_t [3:0] gp_q;    // r0..r3
   logic        wr_hit;  // dest is a general register
   logic [1:0]  wr_idx;

   assign wr_hit = (wb.dest >= sel_first_gp) && (wb.dest <= sel_first_gp + 4'd3);
   assign wr_idx = 2'(wb.dest - sel_first_gp);

   always_ff @(posedge clk) begin
      if (rst) begin
         gp_q <= '0;
      end else if (wb.en && wr_hit) begin
         gp_q[wr_idx] <= wb.data;
      end
   end

   // one read port, constants first, then bypass, then array
   function automatic word_t read_port(reg_sel_t sel, wb_t w, word_t [3:0] regs);
      reg_sel_t idx;
      idx = sel - sel_first_gp;
      if (sel == sel_zero) begin
         return 16'h0000;
      end else if (sel == sel_one) begin
         return 16'h0001;
      end else if (w.en && (w.dest == sel)) begin
         return w.data;                      // write in flight this cycle
      end else if (sel <= sel_first_gp + 4'd3) begin
         return regs[idx[1:0]];
      end
      return 16'h0000;
   endfunction

   assign rd_a = read_port(rd_sel_a, wb, gp_q);
   assign rd_b = read_port(rd_sel_b, wb, gp_q);

   // decoded dest fields come straight from the instr, so code 0/1 targets land here
   a_write_gp_only: assert property (@(posedge clk) disable iff (rst) wb.en |-> wr_hit)
      else $error("write to reserved register code %0d", wb.dest);

endmodule

// File: rtl/execute_stage.sv
// single-cycle ALU, no flags; CMP is an unsigned compare returning 1 or 0
`timescale 1ns/10ps

module execute_stage import grp16_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  decode_pkt_t dec,
   output wb_t         wb
);

   decode_pkt_t dec_q;
   word_t       op_b;
   word_t       result;

   ////////////////////////////////////////////////////////////
   // decode/execute register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_q.reg_write <= 1'b0;   // no write-back out of reset
      end else begin
         dec_q <= dec;
      end
   end

   ////////////////////////////////////////////////////////////
   // alu
   ////////////////////////////////////////////////////////////
   assign op_b = dec_q.use_imm ? dec_q.imm : dec_q.b;   // LI takes imm

   always_comb begin
      case (dec_q.alu_op)
         alu_and: result = dec_q.a & op_b;
         alu_or:  result = dec_q.a | op_b;
         alu_add: result = dec_q.a + op_b;
         alu_sub: result = dec_q.a - op_b;   // wraps
         alu_slt: result = (dec_q.a < op_b) ? 16'h0001 : 16'h0000;
         default: result = '0;
      endcase
   end

   assign wb.en   = dec_q.reg_write;
   assign wb.dest = dec_q.dest;
   assign wb.data = result;

endmodule

// File: rtl/grp16_core.sv
// no stalls or flush; redirect is only safe while single-word instructions are in flight
`timescale 1ns/10ps

module grp16_core import grp16_pkg::*; #(
   parameter int mem_depth = 512
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  load_en,
   input  word_t load_addr,
   input  word_t load_data,
   input  logic  redirect,
   input  word_t redirect_pc,
   output word_t pc,
   output wb_t   wb
);

   word_t       fetch_word;
   instr_pkt_t  instr;
   reg_sel_t    rd_sel_a;
   reg_sel_t    rd_sel_b;
   word_t       rd_a;
   word_t       rd_b;
   decode_pkt_t dec;

   ////////////////////////////////////////////////////////////
   // fetch and word pairing
   ////////////////////////////////////////////////////////////
   fetch_unit #(
      .mem_depth (mem_depth)
   ) fetch_i (
      .clk         (clk),
      .rst         (rst),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .pc          (pc),
      .fetch_word  (fetch_word)
   );

   word_assembler asm_i (
      .clk        (clk),
      .rst        (rst),
      .fetch_word (fetch_word),
      .instr      (instr)
   );

   ////////////////////////////////////////////////////////////
   // decode, register read, execute
   ////////////////////////////////////////////////////////////
   decoder dec_i (
      .instr    (instr),
      .rd_sel_a (rd_sel_a),
      .rd_sel_b (rd_sel_b),
      .rd_a     (rd_a),
      .rd_b     (rd_b),
      .dec      (dec)
   );

   reg_file rf_i (
      .clk      (clk),
      .rst      (rst),
      .rd_sel_a (rd_sel_a),
      .rd_sel_b (rd_sel_b),
      .rd_a     (rd_a),
      .rd_b     (rd_b),
      .wb       (wb)        // write-back also leaves the core
   );

   execute_stage ex_i (
      .clk (clk),
      .rst (rst),
      .dec (dec),
      .wb  (wb)
   );

endmodule

// File: tb/clk_gen.sv
// free-running clock and power-on reset only; reset is released on a falling edge
`timescale 1ns/10ps

module clk_gen #(
   parameter real period     = 8.0,
   parameter int  rst_cycles = 5
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(period / 2.0) clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (rst_cycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;   // away from the active edge
   end

endmodule

// File: tb/grp16_tb.sv
// programs load at address 1 while the core is held in reset; address 0 always holds a NOP
`timescale 1ns/10ps

module grp16_tb import grp16_pkg::*; ();

   localparam int    depth      = 512;
   localparam int    wait_limit = 40;        // cycles allowed per write-back event
   localparam word_t mul_instr  = 16'h4523;  // dropped multiply
   localparam word_t sw_instr   = 16'h3234;  // dropped store

   logic  clk;
   logic  rst_gen;
   logic  hold_rst;   // per-test restart
   logic  rst;
   logic  load_en;
   word_t load_addr;
   word_t load_data;
   logic  redirect;
   word_t redirect_pc;
   word_t pc;
   wb_t   wb;

   integer seed = 32'h3d8;
   int     errors;
   int     checks;
   int     tests_run;
   int     tests_failed;
   wb_t    exp_q [$];        // expected write-back records, in order
   word_t  model_regs [4];   // r0..r3 of the reference model

   assign rst = rst_gen | hold_rst;

   clk_gen clk_i (
      .clk (clk),
      .rst (rst_gen)
   );

   grp16_core #(
      .mem_depth (depth)
   ) dut_i (
      .clk         (clk),
      .rst         (rst),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .pc          (pc),
      .wb          (wb)
   );

   ////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////
   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_reg(input string name, input reg_sel_t got, input reg_sel_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////
   function automatic word_t encode_instr(opcode_t op, reg_sel_t hi, reg_sel_t lo);
      return {op, hi, lo};
   endfunction

   function automatic word_t read_model(reg_sel_t s);
      if (s == sel_zero) return 16'h0000;
      if (s == sel_one) return 16'h0001;
      if (s >= 4'd2 && s <= 4'd5) return model_regs[s - 4'd2];
      return 16'h0000;   // unused codes
   endfunction

   task automatic build_expected(input word_t prog[$]);
      int       i;
      word_t    w;
      word_t    a;
      word_t    b;
      word_t    r;
      reg_sel_t hi;
      logic     valid;
      exp_q = {};
      for (i = 0; i < 4; i++) model_regs[i] = '0;   // regs clear on reset
      i = 0;
      while (i < prog.size()) begin
         w     = prog[i];
         hi    = w[7:4];
         valid = 1'b1;
         if (w[15]) begin                 // long form, imm follows
            r     = prog[i + 1];
            valid = (w[15:8] == op_li);
            i += 2;
         end else begin
            a = read_model(hi);
            b = read_model(w[3:0]);
            case (w[15:8])
               op_add:  r = a + b;
               op_sub:  r = a - b;
               op_and:  r = a & b;
               op_or:   r = a | b;
               op_cmp:  r = (a < b) ? 16'h0001 : 16'h0000;
               default: valid = 1'b0;   // nop and dropped ops
            endcase
            i += 1;
         end
         if (valid) begin
            exp_q.push_back('{en: 1'b1, dest: hi, data: r});
            model_regs[hi - 4'd2] = r;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // program load and event collection
   ////////////////////////////////////////////////////////////
   task automatic load_program(input word_t prog[$], input int base);
      int a;
      @(negedge clk);
      hold_rst = 1'b1;
      redirect = 1'b0;
      for (a = 0; a < depth; a++) begin
         load_en   = 1'b1;
         load_addr = word_t'(a);
         if (a >= base && a - base < prog.size()) begin
            load_data = prog[a - base];
         end else begin
            load_data = nop_instr;   // idle fill
         end
         @(negedge clk);
      end
      load_en  = 1'b0;
      hold_rst = 1'b0;   // core starts at pc 0 from here
   endtask

   task automatic collect_events();
      int n;
      int k;
      int extra;
      for (n = 0; n < exp_q.size(); n++) begin
         k = 0;
         while (wb.en !== 1'b1 && k < wait_limit) begin
            @(negedge clk);
            k++;
         end
         if (wb.en !== 1'b1) begin
            errors++;
            $display("Error at %0t ns: write-back event %0d never arrived", $time, n);
            return;
         end
         check_reg("wb.dest", wb.dest, exp_q[n].dest);
         check_word("wb.data", wb.data, exp_q[n].data);
         @(negedge clk);
      end
      extra = 0;
      repeat (12) begin   // only NOPs remain
         if (wb.en !== 1'b0) extra++;
         @(negedge clk);
      end
      if (extra != 0) begin
         errors++;
         $display("Error at %0t ns: %0d unexpected write-back cycles", $time, extra);
      end
   endtask

   task automatic run_program(input word_t prog[$]);
      build_expected(prog);
      load_program(prog, 1);
      collect_events();
   endtask

   task automatic finish_test(input string name, input int err0);
      tests_run++;
      if (errors != err0) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - err0);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////
   task automatic test_reset_idle();
      word_t prog [$];
      int    err0;
      int    seen;
      err0 = errors;
      seen = 0;
      load_program(prog, 1);
      check_word("pc", pc, 16'h0000);   // first cycle out of reset
      repeat (20) begin
         @(negedge clk);
         if (wb.en !== 1'b0) seen++;
      end
      if (seen != 0) begin
         errors++;
         $display("Error at %0t ns: write-back seen while only NOPs run", $time);
      end
      finish_test("reset_idle", err0);
   endtask

   task automatic test_li_all();
      word_t prog [$];
      int    err0;
      int    c;
      err0 = errors;
      for (c = 2; c <= 5; c++) begin
         prog.push_back(encode_instr(op_li, reg_sel_t'(c), 4'd0));
         prog.push_back(word_t'($random(seed)));
      end
      run_program(prog);
      finish_test("li_all", err0);
   endtask

   task automatic test_alu_ops();
      word_t prog [$];
      word_t v [4];
      int    err0;
      int    i;
      err0 = errors;
      for (i = 0; i < 4; i++) v[i] = word_t'($random(seed));
      prog = {encode_instr(op_li, 4'd2, 4'd0), v[0], encode_instr(op_li, 4'd3, 4'd0), v[1],
              encode_instr(op_li, 4'd4, 4'd0), v[2], encode_instr(op_li, 4'd5, 4'd0), v[3],
              encode_instr(op_add, 4'd2, 4'd3),   // r0 += r1
              encode_instr(op_sub, 4'd3, 4'd2),   // reads r0 via bypass
              encode_instr(op_and, 4'd4, 4'd3),
              encode_instr(op_or,  4'd5, 4'd4),
              encode_instr(op_cmp, 4'd2, 4'd5),
              encode_instr(op_cmp, 4'd5, 4'd2),
              encode_instr(op_add, 4'd2, 4'd2)};
      run_program(prog);
      finish_test("alu_ops", err0);
   endtask

   task automatic test_const_src();
      word_t prog [$];
      word_t v0;
      word_t v1;
      int    err0;
      err0 = errors;
      v0   = word_t'($random(seed));
      v1   = word_t'($random(seed));
      prog = {encode_instr(op_li, 4'd2, 4'd0), v0, encode_instr(op_li, 4'd3, 4'd0), v1,
              encode_instr(op_add, 4'd2, sel_one),    // r0 + 1
              encode_instr(op_sub, 4'd3, sel_one),
              encode_instr(op_and, 4'd3, sel_zero),   // r1 = 0
              encode_instr(op_cmp, 4'd2, sel_zero),   // never below zero
              encode_instr(op_cmp, 4'd3, sel_one),
              encode_instr(op_or,  4'd5, sel_one)};
      run_program(prog);
      finish_test("const_src", err0);
   endtask

   task automatic test_skip_ops();
      word_t prog [$];
      int    err0;
      err0 = errors;
      prog = {encode_instr(op_li, 4'd2, 4'd0), word_t'($random(seed)),
              nop_instr, mul_instr, sw_instr,
              encode_instr(op_add, 4'd3, 4'd2),
              nop_instr,
              encode_instr(op_li, 4'd5, 4'd0), 16'h8001};   // imm with bit 15 set
      run_program(prog);
      finish_test("skip_ops", err0);
   endtask

   task automatic test_redirect();
      word_t prog [$];
      int    err0;
      err0 = errors;
      prog = {encode_instr(op_li, 4'd4, 4'd0), word_t'($random(seed))};
      build_expected(prog);
      load_program(prog, 64);   // only reachable by the jump
      repeat (3) @(negedge clk);
      redirect    = 1'b1;
      redirect_pc = 16'd64;
      @(negedge clk);
      redirect = 1'b0;
      check_word("pc", pc, 16'd64);
      collect_events();
      finish_test("redirect", err0);
   endtask

   ////////////////////////////////////////////////////////////
   // sequence
   ////////////////////////////////////////////////////////////
   initial begin
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      hold_rst     = 1'b1;
      load_en      = 1'b0;
      load_addr    = '0;
      load_data    = '0;
      redirect     = 1'b0;
      redirect_pc  = '0;

      test_reset_idle();
      test_li_all();
      test_alu_ops();
      test_const_src();
      test_skip_ops();
      test_redirect();

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
rtl/grp16_pkg.sv
rtl/fetch_unit.sv
rtl/word_assembler.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/grp16_core.sv
tb/clk_gen.sv
tb/grp16_tb.sv
